/* common/debug_pkg.sv */
`default_nettype none

package debug_pkg;

    // UART and processor widths
    localparam int NB_DATA        = 8;
    localparam int NB_WORD        = 32;
    localparam int BYTES_PER_WORD = 4;
    localparam int NB_BYTE_SEL    = 2;   // Lane index inside a word

    // Instruction memory, loaded one byte per UART frame
    localparam int IM_DEPTH   = 256;
    localparam int NB_IM_ADDR = 8;

    // Register bank and data memory, dumped word by word
    localparam int RB_DEPTH   = 32;
    localparam int NB_RB_ADDR = 5;
    localparam int DM_DEPTH   = 32;
    localparam int NB_DM_ADDR = 5;

    // Host command bytes
    typedef enum logic [NB_DATA-1:0] {
        CMD_NONE         = 8'd0,
        CMD_LOAD_PROGRAM = 8'd1,
        CMD_RUN          = 8'd2,
        CMD_STEP_MODE    = 8'd3,
        CMD_SEND_REGS    = 8'd4,
        CMD_SEND_MEM     = 8'd5,
        CMD_SEND_PC      = 8'd6,
        CMD_STEP         = 8'd7,
        CMD_CONTINUE     = 8'd8
    } cmd_t;

    // Controller modes, dump states wait for the serializer
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOAD,
        ST_READY,
        ST_RUN,
        ST_STEP_WAIT,
        ST_DUMP_PC,
        ST_DUMP_MEM,
        ST_DUMP_REGS
    } ctrl_state_t;

    typedef enum logic [1:0] {
        DUMP_PC,
        DUMP_MEM,
        DUMP_REGS
    } dump_t;

endpackage

`default_nettype wire

/* rtl/debug_cmd_receiver.sv */
`timescale 1ns/1ps
`default_nettype none

module debug_cmd_receiver import debug_pkg::*; (
    input  wire logic                  i_clock,
    input  wire logic                  i_reset,
    input  wire logic                  i_rx_done,
    input  wire logic [NB_DATA-1:0]    i_rx_data,
    input  wire logic                  i_load_start,
    output logic                       o_cmd_valid,
    output cmd_t                       o_cmd,
    output logic                       o_im_write_enable,
    output logic [NB_IM_ADDR-1:0]      o_im_addr,
    output logic [NB_DATA-1:0]         o_im_data,
    output logic                       o_load_done
);

    logic                  load_mode;   // Bytes go to instruction memory
    logic [NB_IM_ADDR-1:0] im_count;    // Next write address
    logic                  rx_known;

    // CMD_NONE and anything past CMD_CONTINUE are dropped
    assign rx_known = (i_rx_data >= CMD_LOAD_PROGRAM) && (i_rx_data <= CMD_CONTINUE);

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            load_mode         <= 1'b0;
            im_count          <= '0;
            o_cmd_valid       <= 1'b0;
            o_im_write_enable <= 1'b0;
            o_load_done       <= 1'b0;
        end else begin
            o_cmd_valid       <= 1'b0;
            o_im_write_enable <= 1'b0;
            o_load_done       <= 1'b0;
            if (i_load_start) begin
                load_mode <= 1'b1;
                im_count  <= '0;
            end else if (i_rx_done) begin
                if (load_mode) begin
                    o_im_write_enable <= 1'b1;
                    im_count          <= im_count + 1'b1;
                    // Last program byte, back to command decoding
                    if (im_count == NB_IM_ADDR'(IM_DEPTH - 1)) begin
                        o_load_done <= 1'b1;
                        load_mode   <= 1'b0;
                    end
                end else begin
                    o_cmd_valid <= rx_known;
                end
            end
        end
    end

    // Payload captured on every strobe, qualified by the valid flags
    always_ff @(posedge i_clock) begin
        if (i_rx_done) begin
            o_cmd     <= cmd_t'(i_rx_data);
            o_im_addr <= im_count;
            o_im_data <= i_rx_data;
        end
    end

endmodule

`default_nettype wire

/* rtl/debug_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module debug_controller import debug_pkg::*; (
    input  wire logic  i_clock,
    input  wire logic  i_reset,
    input  wire logic  i_cmd_valid,
    input  wire cmd_t  i_cmd,
    input  wire logic  i_load_done,
    input  wire logic  i_hlt,
    input  wire logic  i_dump_done,
    output logic       o_load_start,
    output logic       o_dump_start,
    output dump_t      o_dump_kind,
    output logic       o_run_enable,
    output logic       o_step_mode,
    output logic       o_step
);

    ctrl_state_t state;
    logic        ret_step;   // Dump chain was started by a step

    // Processor only clocks in these two modes
    assign o_run_enable = (state == ST_RUN) || (state == ST_STEP_WAIT);
    assign o_step_mode  = (state == ST_STEP_WAIT);

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state        <= ST_IDLE;
            ret_step     <= 1'b0;
            o_load_start <= 1'b0;
            o_dump_start <= 1'b0;
            o_dump_kind  <= DUMP_PC;
            o_step       <= 1'b0;
        end else begin
            o_load_start <= 1'b0;
            o_dump_start <= 1'b0;
            o_step       <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (i_cmd_valid) begin
                        ret_step <= 1'b0;
                        case (i_cmd)
                            CMD_LOAD_PROGRAM: begin
                                state        <= ST_LOAD;
                                o_load_start <= 1'b1;
                            end
                            CMD_SEND_PC: begin
                                state        <= ST_DUMP_PC;
                                o_dump_start <= 1'b1;
                                o_dump_kind  <= DUMP_PC;
                            end
                            CMD_SEND_MEM: begin
                                state        <= ST_DUMP_MEM;
                                o_dump_start <= 1'b1;
                                o_dump_kind  <= DUMP_MEM;
                            end
                            CMD_SEND_REGS: begin
                                state        <= ST_DUMP_REGS;
                                o_dump_start <= 1'b1;
                                o_dump_kind  <= DUMP_REGS;
                            end
                            default: ;   // Not valid here
                        endcase
                    end
                end
                ST_LOAD: begin
                    if (i_load_done) state <= ST_READY;
                end
                ST_READY: begin
                    if (i_cmd_valid && (i_cmd == CMD_RUN)) state <= ST_RUN;
                    if (i_cmd_valid && (i_cmd == CMD_STEP_MODE)) state <= ST_STEP_WAIT;
                end
                ST_RUN: begin
                    if (i_hlt) state <= ST_IDLE;
                end
                ST_STEP_WAIT: begin
                    if (i_hlt) begin
                        state <= ST_IDLE;
                    end else if (o_step) begin
                        // Step cycle is over, report PC first
                        state        <= ST_DUMP_PC;
                        ret_step     <= 1'b1;
                        o_dump_start <= 1'b1;
                        o_dump_kind  <= DUMP_PC;
                    end else if (i_cmd_valid) begin
                        if (i_cmd == CMD_STEP) o_step <= 1'b1;
                        if (i_cmd == CMD_CONTINUE) state <= ST_RUN;
                    end
                end
                ST_DUMP_PC: begin
                    if (i_dump_done) begin
                        if (ret_step) begin
                            state        <= ST_DUMP_MEM;
                            o_dump_start <= 1'b1;
                            o_dump_kind  <= DUMP_MEM;
                        end else begin
                            state <= ST_IDLE;
                        end
                    end
                end
                ST_DUMP_MEM: begin
                    if (i_dump_done) begin
                        if (ret_step) begin
                            state        <= ST_DUMP_REGS;
                            o_dump_start <= 1'b1;
                            o_dump_kind  <= DUMP_REGS;
                        end else begin
                            state <= ST_IDLE;
                        end
                    end
                end
                ST_DUMP_REGS: begin
                    if (i_dump_done) state <= ret_step ? ST_STEP_WAIT : ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/dump_serializer.sv */
`timescale 1ns/1ps
`default_nettype none

module dump_serializer import debug_pkg::*; (
    input  wire logic                  i_clock,
    input  wire logic                  i_reset,
    input  wire logic                  i_dump_start,
    input  wire dump_t                 i_dump_kind,
    input  wire logic [NB_WORD-1:0]    i_pc_value,
    input  wire logic [NB_WORD-1:0]    i_rb_data,
    input  wire logic [NB_WORD-1:0]    i_dm_data,
    input  wire logic                  i_tx_done,
    output logic [NB_RB_ADDR-1:0]      o_rb_addr,
    output logic                       o_rb_read_enable,
    output logic [NB_DM_ADDR-1:0]      o_dm_addr,
    output logic                       o_dm_read_enable,
    output logic [NB_DATA-1:0]         o_tx_data,
    output logic                       o_tx_start,
    output logic                       o_dump_done
);

    logic                   busy;
    dump_t                  kind;
    logic [NB_DM_ADDR-1:0]  word_addr;   // Shared by both memories
    logic [NB_BYTE_SEL-1:0] lane;        // 0 is the MSB lane
    logic [NB_DM_ADDR-1:0]  last_word;
    logic [NB_WORD-1:0]     word;
    logic                   last_byte;

    // Word source and length by dump kind
    always_comb begin
        case (kind)
            DUMP_PC: begin
                word      = i_pc_value;
                last_word = '0;
            end
            DUMP_REGS: begin
                word      = i_rb_data;
                last_word = NB_DM_ADDR'(RB_DEPTH - 1);
            end
            default: begin
                word      = i_dm_data;
                last_word = NB_DM_ADDR'(DM_DEPTH - 1);
            end
        endcase
    end

    assign last_byte = (lane == NB_BYTE_SEL'(BYTES_PER_WORD - 1)) && (word_addr == last_word);

    // Byte taken straight from the live read data
    assign o_tx_data = word[NB_WORD - 1 - int'(lane) * NB_DATA -: NB_DATA];

    assign o_rb_addr        = NB_RB_ADDR'(word_addr);
    assign o_dm_addr        = word_addr;
    assign o_rb_read_enable = busy && (kind == DUMP_REGS);
    assign o_dm_read_enable = busy && (kind == DUMP_MEM);

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            busy        <= 1'b0;
            kind        <= DUMP_PC;
            word_addr   <= '0;
            lane        <= '0;
            o_tx_start  <= 1'b0;
            o_dump_done <= 1'b0;
        end else begin
            o_dump_done <= 1'b0;
            if (i_dump_start && !busy) begin
                busy      <= 1'b1;
                kind      <= i_dump_kind;
                word_addr <= '0;
                lane      <= '0;
            end else if (busy) begin
                if (!o_tx_start) begin
                    o_tx_start <= 1'b1;   // Read data settled, offer first byte
                end else if (i_tx_done) begin
                    if (last_byte) begin
                        busy        <= 1'b0;
                        o_tx_start  <= 1'b0;
                        o_dump_done <= 1'b1;
                    end else begin
                        lane <= lane + 1'b1;
                        if (lane == NB_BYTE_SEL'(BYTES_PER_WORD - 1)) begin
                            word_addr <= word_addr + 1'b1;
                        end
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/debug_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module debug_unit import debug_pkg::*; (
    input  wire logic                  i_clock,
    input  wire logic                  i_reset,
    input  wire logic                  i_hlt,
    input  wire logic                  i_rx_done,
    input  wire logic [NB_DATA-1:0]    i_rx_data,
    input  wire logic                  i_tx_done,
    input  wire logic [NB_WORD-1:0]    i_pc_value,
    input  wire logic [NB_WORD-1:0]    i_rb_data,
    input  wire logic [NB_WORD-1:0]    i_dm_data,
    output logic                       o_im_write_enable,
    output logic [NB_IM_ADDR-1:0]      o_im_addr,
    output logic [NB_DATA-1:0]         o_im_data,
    output logic [NB_RB_ADDR-1:0]      o_rb_addr,
    output logic                       o_rb_read_enable,
    output logic [NB_DM_ADDR-1:0]      o_dm_addr,
    output logic                       o_dm_read_enable,
    output logic [NB_DATA-1:0]         o_tx_data,
    output logic                       o_tx_start,
    output logic                       o_run_enable,
    output logic                       o_step_mode,
    output logic                       o_step
);

    logic  cmd_valid;
    cmd_t  cmd;
    logic  load_start;
    logic  load_done;
    logic  dump_start;
    dump_t dump_kind;
    logic  dump_done;

    // UART RX side
    debug_cmd_receiver cmd_receiver_i (
        .i_clock           (i_clock),
        .i_reset           (i_reset),
        .i_rx_done         (i_rx_done),
        .i_rx_data         (i_rx_data),
        .i_load_start      (load_start),
        .o_cmd_valid       (cmd_valid),
        .o_cmd             (cmd),
        .o_im_write_enable (o_im_write_enable),
        .o_im_addr         (o_im_addr),
        .o_im_data         (o_im_data),
        .o_load_done       (load_done)
    );

    debug_controller controller_i (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_cmd_valid  (cmd_valid),
        .i_cmd        (cmd),
        .i_load_done  (load_done),
        .i_hlt        (i_hlt),
        .i_dump_done  (dump_done),
        .o_load_start (load_start),
        .o_dump_start (dump_start),
        .o_dump_kind  (dump_kind),
        .o_run_enable (o_run_enable),
        .o_step_mode  (o_step_mode),
        .o_step       (o_step)
    );

    // UART TX side
    dump_serializer serializer_i (
        .i_clock          (i_clock),
        .i_reset          (i_reset),
        .i_dump_start     (dump_start),
        .i_dump_kind      (dump_kind),
        .i_pc_value       (i_pc_value),
        .i_rb_data        (i_rb_data),
        .i_dm_data        (i_dm_data),
        .i_tx_done        (i_tx_done),
        .o_rb_addr        (o_rb_addr),
        .o_rb_read_enable (o_rb_read_enable),
        .o_dm_addr        (o_dm_addr),
        .o_dm_read_enable (o_dm_read_enable),
        .o_tx_data        (o_tx_data),
        .o_tx_start       (o_tx_start),
        .o_dump_done      (dump_done)
    );

endmodule

`default_nettype wire

/* sim/debug_unit_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module debug_unit_sva import debug_pkg::*; (
    input wire logic               i_clock,
    input wire logic               i_reset,
    input wire logic               i_tx_done,
    input wire logic [NB_DATA-1:0] o_tx_data,
    input wire logic               o_tx_start,
    input wire logic               o_step,
    input wire logic               o_run_enable,
    input wire logic               o_rb_read_enable,
    input wire logic               o_dm_read_enable,
    input wire logic               o_im_write_enable
);

    int unsigned error_count = 0;   // Failures seen so far

    step_one_cycle: assert property (@(posedge i_clock) disable iff (i_reset)
        o_step |=> !o_step)
    else begin
        $error("o_step stayed high for more than one cycle");
        error_count++;
    end

    // Byte on offer holds until the transmitter takes it
    tx_data_stable: assert property (@(posedge i_clock) disable iff (i_reset)
        o_tx_start && !i_tx_done |=> $stable(o_tx_data))
    else begin
        $error("o_tx_data changed before i_tx_done");
        error_count++;
    end

    run_no_read: assert property (@(posedge i_clock) disable iff (i_reset)
        !(o_run_enable && (o_rb_read_enable || o_dm_read_enable)))
    else begin
        $error("debug read while the processor runs");
        error_count++;
    end

    load_no_tx: assert property (@(posedge i_clock) disable iff (i_reset)
        !(o_im_write_enable && o_tx_start))
    else begin
        $error("program write during a transmit");
        error_count++;
    end

endmodule

bind debug_unit debug_unit_sva sva_i (
    .i_clock           (i_clock),
    .i_reset           (i_reset),
    .i_tx_done         (i_tx_done),
    .o_tx_data         (o_tx_data),
    .o_tx_start        (o_tx_start),
    .o_step            (o_step),
    .o_run_enable      (o_run_enable),
    .o_rb_read_enable  (o_rb_read_enable),
    .o_dm_read_enable  (o_dm_read_enable),
    .o_im_write_enable (o_im_write_enable)
);

`default_nettype wire

/* sim/debug_unit_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module debug_unit_tb import debug_pkg::*; ();

    localparam int          CLK_PERIOD   = 20;
    localparam int          DRIVE_DELAY  = 2;   // Inputs change this long after the rising edge
    localparam int          RESET_CYCLES = 5;
    localparam logic [31:0] SEED         = 32'h0782_8c55;
    localparam logic [31:0] PC_VALUE     = 32'h0000_1234;

    // Every byte crossing the UART in both directions
    localparam int TX_BYTES   = 4 + 4 * RB_DEPTH + 4 * DM_DEPTH + 4 * (1 + DM_DEPTH + RB_DEPTH);
    localparam int RX_BYTES   = 2 * (IM_DEPTH + 1) + 8;
    localparam int TIMEOUT_NS = (RESET_CYCLES + (TX_BYTES + RX_BYTES) * 10) * CLK_PERIOD;

    logic                  i_clock;
    logic                  i_reset;
    logic                  i_hlt;
    logic                  i_rx_done;
    logic [NB_DATA-1:0]    i_rx_data;
    logic                  i_tx_done;
    logic [NB_WORD-1:0]    i_pc_value;
    logic [NB_WORD-1:0]    i_rb_data;
    logic [NB_WORD-1:0]    i_dm_data;
    logic                  o_im_write_enable;
    logic [NB_IM_ADDR-1:0] o_im_addr;
    logic [NB_DATA-1:0]    o_im_data;
    logic [NB_RB_ADDR-1:0] o_rb_addr;
    logic                  o_rb_read_enable;
    logic [NB_DM_ADDR-1:0] o_dm_addr;
    logic                  o_dm_read_enable;
    logic [NB_DATA-1:0]    o_tx_data;
    logic                  o_tx_start;
    logic                  o_run_enable;
    logic                  o_step_mode;
    logic                  o_step;

    logic [31:0]                   lcg_state = SEED;
    logic [NB_DATA-1:0]            tx_expected[$];   // Bytes the next dumps must produce
    logic [NB_IM_ADDR+NB_DATA-1:0] im_expected[$];   // {address, data} of pending writes

    debug_unit debug_unit_i (.*);

    function automatic logic [NB_WORD-1:0] reg_model(input logic [NB_RB_ADDR-1:0] addr);
        return NB_WORD'(addr) * 32'h0101_0101 + 32'h1000_0000;
    endfunction

    function automatic logic [NB_WORD-1:0] mem_model(input logic [NB_DM_ADDR-1:0] addr);
        return NB_WORD'(addr) * 32'h0001_0001 + 32'hA000_0000;
    endfunction

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Register bank and data memory answer in the same cycle while read enabled
    assign i_rb_data  = o_rb_read_enable ? reg_model(o_rb_addr) : '0;
    assign i_dm_data  = o_dm_read_enable ? mem_model(o_dm_addr) : '0;
    assign i_pc_value = PC_VALUE;

    initial begin
        i_clock = 1'b0;
        forever #(CLK_PERIOD / 2) i_clock = ~i_clock;
    end

    task automatic stop_on_failure();
        $display("tests failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [NB_WORD-1:0] expected,
                                   input logic [NB_WORD-1:0] actual);
        $display("Fail at %0t ns: %s expected 0x%08h, got 0x%08h", $time, name, expected, actual);
        stop_on_failure();
    endtask

    task automatic report_error(input string what);
        $display("Error at %0t ns: %s", $time, what);
        stop_on_failure();
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        assert (actual === expected)
            else report_mismatch(name, NB_WORD'(expected), NB_WORD'(actual));
    endtask

    task automatic check_outputs_low();
        check_bit("o_tx_start", 1'b0, o_tx_start);
        check_bit("o_im_write_enable", 1'b0, o_im_write_enable);
        check_bit("o_run_enable", 1'b0, o_run_enable);
        check_bit("o_step_mode", 1'b0, o_step_mode);
        check_bit("o_step", 1'b0, o_step);
        check_bit("o_rb_read_enable", 1'b0, o_rb_read_enable);
        check_bit("o_dm_read_enable", 1'b0, o_dm_read_enable);
    endtask

    // Ends at the drive point of a later cycle
    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge i_clock);
            #DRIVE_DELAY;
        end
    endtask

    task automatic send_byte(input logic [NB_DATA-1:0] data);
        i_rx_data = data;
        i_rx_done = 1'b1;
        wait_cycles(1);
        i_rx_done = 1'b0;
    endtask

    // MSB first on the wire
    task automatic expect_word(input logic [NB_WORD-1:0] word);
        for (int lane = 0; lane < BYTES_PER_WORD; lane++) begin
            tx_expected.push_back(NB_DATA'(word >> (NB_DATA * (BYTES_PER_WORD - 1 - lane))));
        end
    endtask

    task automatic expect_regs();
        for (int a = 0; a < RB_DEPTH; a++) expect_word(reg_model(NB_RB_ADDR'(a)));
    endtask

    task automatic expect_mem();
        for (int a = 0; a < DM_DEPTH; a++) expect_word(mem_model(NB_DM_ADDR'(a)));
    endtask

    task automatic wait_dump_end();
        while (tx_expected.size() != 0 || o_tx_start) wait_cycles(1);
    endtask

    task automatic load_program();
        logic [31:0]        rnd;
        logic [NB_DATA-1:0] data;
        send_byte(CMD_LOAD_PROGRAM);
        wait_cycles(3);   // Receiver enters load mode
        for (int addr = 0; addr < IM_DEPTH; addr++) begin
            rnd  = lcg_next();
            data = rnd[23:16];
            im_expected.push_back({NB_IM_ADDR'(addr), data});
            send_byte(data);
            wait_cycles(1);
        end
        while (im_expected.size() != 0) wait_cycles(1);
    endtask

    // UART transmitter with a random busy time per byte
    initial begin
        logic [31:0]        rnd;
        logic [NB_DATA-1:0] expected;
        int                 tx_wait;
        i_tx_done = 1'b0;
        tx_wait   = 0;
        forever begin
            wait_cycles(1);
            i_tx_done = 1'b0;
            if (o_tx_start) begin
                if (tx_wait == 0) begin
                    rnd     = lcg_next();
                    tx_wait = int'(rnd[18:16]) + 1;   // 1 to 8 cycles
                end
                tx_wait = tx_wait - 1;
                if (tx_wait == 0) begin
                    if (tx_expected.size() == 0) begin
                        report_error("the DUT sent a byte while no dump was expected");
                    end else begin
                        expected = tx_expected.pop_front();
                        assert (o_tx_data == expected)
                            else report_mismatch("o_tx_data", NB_WORD'(expected),
                                                 NB_WORD'(o_tx_data));
                    end
                    i_tx_done = 1'b1;
                end
            end
        end
    end

    // Instruction memory writes and bound assertions
    initial begin
        logic [NB_IM_ADDR+NB_DATA-1:0] write;
        forever begin
            wait_cycles(1);
            if (debug_unit_i.sva_i.error_count != 0) begin
                report_error("a bound protocol assertion failed");
            end
            if (o_im_write_enable) begin
                if (im_expected.size() == 0) begin
                    report_error("instruction memory written outside a program load");
                end else begin
                    write = im_expected.pop_front();
                    assert (o_im_addr == write[NB_IM_ADDR+NB_DATA-1:NB_DATA])
                        else report_mismatch("o_im_addr",
                                             NB_WORD'(write[NB_IM_ADDR+NB_DATA-1:NB_DATA]),
                                             NB_WORD'(o_im_addr));
                    assert (o_im_data == write[NB_DATA-1:0])
                        else report_mismatch("o_im_data", NB_WORD'(write[NB_DATA-1:0]),
                                             NB_WORD'(o_im_data));
                end
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        report_error("watchdog timeout, the DUT stopped making progress");
    end

    initial begin
        i_reset   = 1'b1;
        i_hlt     = 1'b0;
        i_rx_done = 1'b0;
        i_rx_data = '0;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            wait_cycles(1);
            check_outputs_low();
        end
        i_reset = 1'b0;
        wait_cycles(1);
        check_outputs_low();

        // Dumps straight from idle
        expect_word(PC_VALUE);
        send_byte(CMD_SEND_PC);
        wait_dump_end();
        expect_regs();
        send_byte(CMD_SEND_REGS);
        wait_dump_end();

        load_program();
        send_byte(CMD_RUN);
        wait_cycles(1);   // Command lands two cycles after its strobe
        check_bit("o_run_enable", 1'b1, o_run_enable);
        i_hlt = 1'b1;
        wait_cycles(1);
        check_bit("o_run_enable", 1'b0, o_run_enable);
        i_hlt = 1'b0;
        expect_mem();
        send_byte(CMD_SEND_MEM);
        wait_dump_end();

        // Single step with the full PC, memory and register report
        load_program();
        send_byte(CMD_STEP_MODE);
        wait_cycles(1);
        check_bit("o_step_mode", 1'b1, o_step_mode);
        expect_word(PC_VALUE);
        expect_mem();
        expect_regs();
        send_byte(CMD_STEP);
        wait_cycles(1);
        check_bit("o_step", 1'b1, o_step);
        wait_cycles(1);
        check_bit("o_step", 1'b0, o_step);
        wait_dump_end();
        while (!o_step_mode) wait_cycles(1);
        send_byte(CMD_CONTINUE);
        wait_cycles(1);
        check_bit("o_run_enable", 1'b1, o_run_enable);
        check_bit("o_step_mode", 1'b0, o_step_mode);

        wait_cycles(2);
        if (tx_expected.size() != 0 || im_expected.size() != 0) begin
            report_error("expected transfers were still pending at the end");
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* all.f */
common/debug_pkg.sv
rtl/debug_cmd_receiver.sv
rtl/debug_controller.sv
rtl/dump_serializer.sv
rtl/debug_unit.sv
sim/debug_unit_sva.sv
sim/debug_unit_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       := debug_unit_tb
FILELIST  := all.f
OBJ_DIR   := obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
